// File: design/cnu_pkg.sv
// min-sum check node definitions
package cnu_pkg;

    localparam int DEGREE    = 6;
    localparam int MAG_W     = 5;
    localparam int IDX_W     = 3;
    localparam int NUM_PAIRS = DEGREE / 2;

    ////////////////////
    // messages
    ////////////////////

    // sign-magnitude message
    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } msg_t;

    typedef msg_t [DEGREE-1:0] msg_vec_t;

    // partial minimum search result
    typedef struct packed {
        logic [MAG_W-1:0] min1;
        logic [MAG_W-1:0] min2;
        logic [IDX_W-1:0] idx;
    } min_rec_t;

    ////////////////////
    // pipeline records
    ////////////////////

    typedef struct packed {
        logic              valid;
        msg_vec_t          msgs;
        logic [DEGREE-1:0] hard_bits;
    } check_in_t;

    typedef struct packed {
        logic                        valid;
        min_rec_t [NUM_PAIRS-1:0]    recs;
        logic     [NUM_PAIRS-1:0]    pair_sign;
        logic     [NUM_PAIRS-1:0]    pair_parity;
        logic     [DEGREE-1:0]       signs;
    } sort_stage_t;

    typedef struct packed {
        logic              valid;
        min_rec_t          rec_a;
        min_rec_t          rec_b;
        logic              sign_prod;
        logic              parity;
        logic [DEGREE-1:0] signs;
    } merge_stage_t;

    typedef struct packed {
        logic     valid;
        msg_vec_t msgs;
        logic     parity;
    } check_out_t;

    ////////////////////
    // min-pair merge
    ////////////////////

    function automatic logic [MAG_W-1:0] min_mag(input logic [MAG_W-1:0] a,
                                                 input logic [MAG_W-1:0] b);
        return (b < a) ? b : a;
    endfunction

    // lo covers the lower lanes, so a tie keeps the lower index
    function automatic min_rec_t merge_min(input min_rec_t lo, input min_rec_t hi);
        min_rec_t res;
        if (hi.min1 < lo.min1) begin
            res.min1 = hi.min1;
            res.idx  = hi.idx;
            res.min2 = min_mag(lo.min1, hi.min2);
        end else begin
            res.min1 = lo.min1;
            res.idx  = lo.idx;
            res.min2 = min_mag(hi.min1, lo.min2);
        end
        return res;
    endfunction

endpackage

// File: design/pair_sorter.sv
// check node pair sorter
`timescale 1ns/1ps

module pair_sorter (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cnu_pkg::check_in_t   check_in,
    output cnu_pkg::sort_stage_t sorted
);

    import cnu_pkg::*;

    min_rec_t [NUM_PAIRS-1:0] pair_rec;
    logic     [NUM_PAIRS-1:0] pair_sign;
    logic     [NUM_PAIRS-1:0] pair_par;
    logic     [DEGREE-1:0]    in_signs;

    ////////////////////
    // pairwise compare
    ////////////////////

    always_comb begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            // odd lane only on a strict win
            if (check_in.msgs[2*p+1].mag < check_in.msgs[2*p].mag) begin
                pair_rec[p].min1 = check_in.msgs[2*p+1].mag;
                pair_rec[p].min2 = check_in.msgs[2*p].mag;
                pair_rec[p].idx  = IDX_W'(2*p+1);
            end else begin
                pair_rec[p].min1 = check_in.msgs[2*p].mag;
                pair_rec[p].min2 = check_in.msgs[2*p+1].mag;
                pair_rec[p].idx  = IDX_W'(2*p);
            end
            pair_sign[p] = check_in.msgs[2*p].sign ^ check_in.msgs[2*p+1].sign;
            pair_par[p]  = check_in.hard_bits[2*p] ^ check_in.hard_bits[2*p+1];
        end
        for (int i = 0; i < DEGREE; i++) begin
            in_signs[i] = check_in.msgs[i].sign;
        end
    end

    ////////////////////
    // stage register
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sorted <= '0;
        end else begin
            sorted.valid <= check_in.valid;
            if (check_in.valid) begin
                sorted.recs        <= pair_rec;
                sorted.pair_sign   <= pair_sign;
                sorted.pair_parity <= pair_par;
                sorted.signs       <= in_signs;
            end
        end
    end

    a_sorted_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        sorted.valid == $past(check_in.valid)
    ) else $error("sorted valid does not follow input valid");

endmodule

// File: design/merge_stage.sv
// check node merge stage
`timescale 1ns/1ps

module merge_stage (
    input  logic                  clk,
    input  logic                  reset_n,
    input  cnu_pkg::sort_stage_t  sorted,
    output cnu_pkg::merge_stage_t merged
);

    import cnu_pkg::*;

    min_rec_t low_rec;

    // lanes 0..3 combined, lanes 4/5 wait a stage
    assign low_rec = merge_min(sorted.recs[0], sorted.recs[1]);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            merged <= '0;
        end else begin
            merged.valid <= sorted.valid;
            if (sorted.valid) begin
                merged.rec_a     <= low_rec;
                merged.rec_b     <= sorted.recs[2];
                merged.sign_prod <= ^sorted.pair_sign;
                merged.parity    <= ^sorted.pair_parity;
                merged.signs     <= sorted.signs;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    for (genvar r = 0; r < NUM_PAIRS; r++) begin : g_idx_chk
        a_idx_range: assert property (
            @(posedge clk) disable iff (!reset_n)
            sorted.valid |-> (sorted.recs[r].idx < DEGREE)
        ) else $error("record %0d index out of range", r);
    end

endmodule

// File: design/message_builder.sv
// check-to-variable message builder
`timescale 1ns/1ps

module message_builder (
    input  logic                  clk,
    input  logic                  reset_n,
    input  cnu_pkg::merge_stage_t merged,
    output cnu_pkg::check_out_t   check_out
);

    import cnu_pkg::*;

    min_rec_t fin_rec;
    msg_vec_t out_msgs;

    ////////////////////
    // final merge
    ////////////////////

    // rec_a holds lanes 0..3, so it goes first
    assign fin_rec = merge_min(merged.rec_a, merged.rec_b);

    ////////////////////
    // per-lane messages
    ////////////////////

    always_comb begin
        for (int i = 0; i < DEGREE; i++) begin
            // the min1 lane must not see its own value
            if (fin_rec.idx == IDX_W'(i)) begin
                out_msgs[i].mag = fin_rec.min2;
            end else begin
                out_msgs[i].mag = fin_rec.min1;
            end
            // drop own sign from the product
            out_msgs[i].sign = merged.sign_prod ^ merged.signs[i];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_out <= '0;
        end else begin
            check_out.valid <= merged.valid;
            if (merged.valid) begin
                check_out.msgs   <= out_msgs;
                check_out.parity <= merged.parity;
            end
        end
    end

    a_out_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        check_out.valid == $past(merged.valid)
    ) else $error("output valid does not follow merged valid");

endmodule

// File: design/cnu_top.sv
// min-sum check node unit
`timescale 1ns/1ps

module cnu_top (
    input  logic                clk,
    input  logic                reset_n,
    input  cnu_pkg::check_in_t  check_in,
    output cnu_pkg::check_out_t check_out
);

    import cnu_pkg::*;

    sort_stage_t  sorted;
    merge_stage_t merged;

    ////////////////////
    // three stage pipe
    ////////////////////

    pair_sorter i_pair_sorter (
        .clk      (clk),
        .reset_n  (reset_n),
        .check_in (check_in),
        .sorted   (sorted)
    );

    merge_stage i_merge_stage (
        .clk     (clk),
        .reset_n (reset_n),
        .sorted  (sorted),
        .merged  (merged)
    );

    message_builder i_message_builder (
        .clk       (clk),
        .reset_n   (reset_n),
        .merged    (merged),
        .check_out (check_out)
    );

endmodule

// File: tb/cnu_tb.sv
// check node unit testbench
`timescale 1ns/1ps

module cnu_tb;

    import cnu_pkg::*;

    localparam int          TIMEOUT    = 100;
    localparam int          NUM_RANDOM = 200;
    localparam logic [31:0] SEED       = 32'he9a1dbfd;

    logic       clk;
    logic       reset_n;
    check_in_t  check_in;
    check_out_t check_out;

    check_out_t exp_q[$];
    check_out_t last_exp;
    int         errors;
    int         test_start_errs;
    int         tests_run;
    int         in_count;
    int         out_count;
    bit         timed_out;
    string      cur_test;

    cnu_top i_cnu_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .check_in  (check_in),
        .check_out (check_out)
    );

    always #10 clk = ~clk;

    ////////////////////
    // checking
    ////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("FAIL %0t ns: %s = %0h, expected %0h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic compare_result(input check_out_t got, input check_out_t want);
        for (int i = 0; i < DEGREE; i++) begin
            check_value($sformatf("check_out.msgs[%0d].sign", i),
                        64'(got.msgs[i].sign), 64'(want.msgs[i].sign));
            check_value($sformatf("check_out.msgs[%0d].mag", i),
                        64'(got.msgs[i].mag), 64'(want.msgs[i].mag));
        end
        check_value("check_out.parity", 64'(got.parity), 64'(want.parity));
    endtask

    // per-lane magnitude and sign from the min pair
    function automatic check_out_t build_result(input logic [DEGREE-1:0] signs,
                                                input logic [MAG_W-1:0]  min1,
                                                input logic [MAG_W-1:0]  min2,
                                                input int                idx,
                                                input logic              par);
        check_out_t r;
        logic       total;
        r = '0;
        total = ^signs;
        r.valid = 1'b1;
        for (int i = 0; i < DEGREE; i++) begin
            r.msgs[i].sign = total ^ signs[i];
            r.msgs[i].mag  = (i == idx) ? min2 : min1;
        end
        r.parity = par;
        return r;
    endfunction

    // linear scan keeps the lowest lane on a tie
    function automatic check_out_t model(input check_in_t v);
        logic [MAG_W-1:0]  min1;
        logic [MAG_W-1:0]  min2;
        int                idx;
        logic [DEGREE-1:0] signs;
        min1 = v.msgs[0].mag;
        min2 = '1;
        idx = 0;
        for (int i = 1; i < DEGREE; i++) begin
            if (v.msgs[i].mag < min1) begin
                min2 = min1;
                min1 = v.msgs[i].mag;
                idx = i;
            end else if (v.msgs[i].mag < min2) begin
                min2 = v.msgs[i].mag;
            end
        end
        for (int i = 0; i < DEGREE; i++) begin
            signs[i] = v.msgs[i].sign;
        end
        return build_result(signs, min1, min2, idx, ^v.hard_bits);
    endfunction

    always @(negedge clk) begin
        check_out_t want;
        if (reset_n && check_out.valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("ERROR %0t ns: output valid with no vector outstanding", $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                compare_result(check_out, want);
                last_exp = want;
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    function automatic check_in_t random_vec(input bit narrow);
        check_in_t v;
        v.valid = 1'b1;
        for (int i = 0; i < DEGREE; i++) begin
            v.msgs[i].sign = 1'($urandom);
            // narrow range gives plenty of ties
            if (narrow) begin
                v.msgs[i].mag = MAG_W'($urandom_range(0, 3));
            end else begin
                v.msgs[i].mag = MAG_W'($urandom);
            end
        end
        v.hard_bits = DEGREE'($urandom);
        return v;
    endfunction

    task automatic send(input check_in_t v, input check_out_t want);
        @(posedge clk);
        check_in <= v;
        exp_q.push_back(want);
        in_count++;
    endtask

    // payload keeps changing while valid is low
    task automatic idle(input int cycles);
        check_in_t junk;
        repeat (cycles) begin
            @(posedge clk);
            junk = random_vec(1'b0);
            junk.valid = 1'b0;
            check_in <= junk;
        end
    endtask

    task automatic drain();
        int cycles;
        idle(1);
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never came out", exp_q.size());
            timed_out = 1'b1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_start_errs = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (timed_out) begin
            $display("test %s: timed out", cur_test);
        end else if (errors == test_start_errs) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errors - test_start_errs);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic reset_values();
        start_test("reset");
        @(negedge clk);
        check_value("check_out.valid", 64'(check_out.valid), 64'(0));
        check_value("check_out.msgs", 64'(check_out.msgs), 64'(0));
        check_value("check_out.parity", 64'(check_out.parity), 64'(0));
        @(posedge clk);
        reset_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("check_out.valid", 64'(check_out.valid), 64'(0));
            check_value("check_out.msgs", 64'(check_out.msgs), 64'(0));
            check_value("check_out.parity", 64'(check_out.parity), 64'(0));
        end
        end_test();
    endtask

    task automatic directed_vectors();
        int                fd;
        int                n;
        string             line;
        logic [7:0]        col [11];
        check_in_t         v;
        logic [DEGREE-1:0] signs;
        start_test("directed");
        fd = $fopen("tb/cnu_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tb/cnu_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() == 0 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                            col[0], col[1], col[2], col[3], col[4], col[5],
                            col[6], col[7], col[8], col[9], col[10]);
                if (n <= 0) begin
                    continue;
                end
                if (n != 11) begin
                    $display("ERROR: malformed line in tb/cnu_tests.txt: %s", line);
                    errors++;
                    continue;
                end
                v.valid = 1'b1;
                for (int i = 0; i < DEGREE; i++) begin
                    v.msgs[i] = col[i][5:0];
                    signs[i]  = col[i][5];
                end
                v.hard_bits = col[6][DEGREE-1:0];
                send(v, build_result(signs, col[7][MAG_W-1:0], col[8][MAG_W-1:0],
                                     int'(col[9]), col[10][0]));
            end
            $fclose(fd);
            drain();
        end
        end_test();
    endtask

    task automatic single_latency();
        check_in_t v;
        int        cycles;
        start_test("latency");
        v = random_vec(1'b0);
        send(v, model(v));
        idle(1);
        cycles = 0;
        while (!check_out.valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!check_out.valid) begin
            $display("timeout: output valid never rose");
            timed_out = 1'b1;
        end else begin
            // three register stages from the sampling edge
            check_value("latency", 64'(cycles), 64'(3));
            @(negedge clk);
            check_value("check_out.valid", 64'(check_out.valid), 64'(0));
        end
        end_test();
    endtask

    task automatic random_stream(input string name, input bit gaps);
        check_in_t v;
        start_test(name);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (gaps && $urandom_range(0, 2) == 0) begin
                idle($urandom_range(1, 3));
            end
            v = random_vec(n % 4 == 3);
            send(v, model(v));
        end
        drain();
        check_value("output count", 64'(out_count), 64'(in_count));
        end_test();
    endtask

    task automatic output_hold();
        check_in_t v;
        start_test("hold");
        v = random_vec(1'b0);
        send(v, model(v));
        drain();
        for (int c = 0; c < 8; c++) begin
            idle(1);
            @(negedge clk);
            check_value("check_out.valid", 64'(check_out.valid), 64'(0));
            compare_result(check_out, last_exp);
        end
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        reset_n = 1'b0;
        check_in = '0;
        errors = 0;
        tests_run = 0;
        in_count = 0;
        out_count = 0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        reset_values();
        if (!timed_out) directed_vectors();
        if (!timed_out) single_latency();
        if (!timed_out) random_stream("stream back to back", 1'b0);
        if (!timed_out) random_stream("stream with gaps", 1'b1);
        if (!timed_out) output_hold();
        $display("tests %0d, vectors %0d, outputs %0d, errors %0d",
                 tests_run, in_count, out_count, errors);
        if (timed_out || errors != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation passed");
        end
        $finish;
    end

endmodule

// File: tb/cnu_tests.txt
# directed vectors for the check node unit, all values hex
# m0..m5: message, bit 5 sign, bits 4:0 magnitude; hb: hard bits, lane 0 in bit 0
# then expected min1, min2, lane of min1 and hard-bit parity
# m0 m1 m2 m3 m4 m5 hb min1 min2 idx par
# distinct magnitudes
05 0a 0f 14 19 1e 00 05 0a 0 0
1e 19 14 0f 0a 05 01 05 0a 5 1
0c 03 11 07 1b 09 03 03 07 1 0
# minimum on each lane in turn
02 08 09 0a 0b 0c 00 02 08 0 0
08 02 09 0a 0b 0c 02 02 08 1 1
08 09 02 0a 0b 0c 04 02 08 2 1
08 09 0a 02 0b 0c 08 02 08 3 1
08 09 0a 0b 02 0c 10 02 08 4 1
08 09 0a 0b 0c 02 20 02 08 5 1
0c 0b 0a 09 01 08 3f 01 08 4 0
1f 00 1e 1d 1c 1b 15 00 1b 1 1
# two equal minima
04 04 09 0a 0b 0c 00 04 04 0 0
09 04 0a 04 0b 0c 00 04 04 1 0
09 0a 0b 0c 03 03 00 03 03 4 0
06 0a 0b 0c 0d 06 21 06 06 0 0
0a 07 0b 0c 07 0d 06 07 07 1 0
0a 0b 05 0c 0d 05 07 05 05 2 1
# three equal minima
03 03 03 0a 0b 0c 00 03 03 0 0
0a 02 0b 02 0c 02 2a 02 02 1 1
0f 0e 01 0d 01 01 0b 01 01 2 1
# tie on the second smallest only
08 03 08 0a 0b 0c 00 03 08 1 0
10 10 10 10 10 01 00 01 10 5 0
# all zero magnitudes
00 00 00 00 00 00 00 00 00 0 0
00 00 00 00 00 00 3f 00 00 0 0
00 00 00 00 00 00 01 00 00 0 1
# all maximum magnitudes
1f 1f 1f 1f 1f 1f 00 1f 1f 0 0
3f 3f 3f 3f 3f 3f 3f 1f 1f 0 0
1f 1f 1f 1f 1f 1e 10 1e 1f 5 1
1f 1e 1f 1f 1f 1f 00 1e 1f 1 0
# mixed signs
25 0a 2f 14 39 1e 00 05 0a 0 0
25 2a 2f 34 39 3e 3f 05 0a 0 0
05 2a 0f 34 19 3e 2a 05 0a 0 1
2c 23 31 27 3b 29 1c 03 07 1 1
20 21 22 23 24 25 0f 00 01 0 0
3f 00 3f 00 3f 00 31 00 00 1 1
20 3f 20 1f 20 1f 00 00 00 0 0
2b 0b 2b 0b 2c 0a 05 0a 0b 5 0
# assorted
13 27 0e 31 09 2d 19 07 09 1 1
1a 16 32 2e 1c 15 26 0e 12 3 1
01 02 21 22 03 23 0e 01 01 0 1
0d 2d 0c 2c 0b 2b 33 0b 0b 4 0
1e 1d 1c 1b 1a 19 3e 19 1a 5 1
14 2c 07 33 07 2b 09 07 07 2 0
30 11 12 13 14 15 20 10 11 0 1
11 30 12 13 14 15 10 10 11 1 1

// File: sources.f
design/cnu_pkg.sv
design/pair_sorter.sv
design/merge_stage.sv
design/message_builder.sv
design/cnu_top.sv
tb/cnu_tb.sv

// File: Makefile
# Verilator build and run for the check node unit

VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := cnu_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
